/* fetch_pkg.sv */
package fetch_pkg;

	// Cache line geometry
	localparam int words_per_line = 4;
	localparam int line_offset_bits = 4;

	// Burst length field is beats minus one
	localparam logic [3:0] refill_len = 4'(words_per_line - 1);

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01
	} burst_type_t;

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_lookup,
		refill_addr,
		refill_data,
		single_addr,
		single_data,
		deliver
	} fetch_state_t;

	typedef struct packed {
		logic [31:0] addr;
		burst_type_t burst;
		logic [3:0]  len;
	} mem_read_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic        last;
	} mem_read_resp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_out_t;

	typedef struct packed {
		logic [31:0] hits;
		logic [31:0] misses;
		logic [31:0] stall_cycles;
	} perf_counts_t;

endpackage

/* fetch_control.sv */
`timescale 1ns/1ps

module fetch_control #(
	parameter logic [31:0] cache_base  = 32'ha000_0000,
	parameter logic [31:0] cache_limit = 32'ha200_0000,
	parameter logic [31:0] reset_pc    = 32'h3000_0000
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     wb_valid,
	input  logic [31:0]              jump_addr,
	input  logic                     ar_ready,
	input  logic                     r_valid,
	input  fetch_pkg::mem_read_resp_t r,
	input  logic                     idu_ready,
	input  logic                     lookup_hit,
	input  logic [31:0]              lookup_word,
	input  logic [1:0]               beat_index,
	output logic                     ar_valid,
	output fetch_pkg::mem_read_req_t ar,
	output logic                     r_ready,
	output logic                     idu_valid,
	output fetch_pkg::fetch_out_t    out,
	output logic                     lookup_valid,
	output logic [31:0]              lookup_addr,
	output logic                     fill_valid,
	output logic [31:0]              fill_data,
	output logic                     hit_event,
	output logic                     miss_event,
	output logic                     refill_start,
	output logic                     stalled
);
	import fetch_pkg::*;

	fetch_state_t state;
	logic [31:0]  pc;
	logic [31:0]  inst;
	logic         cacheable;
	logic         lookup_sent;
	logic         beat_accept;
	logic         lookup_done;

	assign cacheable = (pc >= cache_base) && (pc < cache_limit);
	assign beat_accept = r_valid && r_ready;

	// Second lookup cycle, where the registered tag compare is visible
	assign lookup_done = (state == fetch_lookup) && lookup_sent;

	// Request depends only on the pc, so it holds while ar_ready is low
	assign ar_valid = (state == refill_addr) || (state == single_addr);
	assign ar.addr = cacheable ? {pc[31:line_offset_bits], {line_offset_bits{1'b0}}} : pc;
	assign ar.burst = cacheable ? burst_incr : burst_fixed;
	assign ar.len = cacheable ? refill_len : 4'd0;

	assign r_ready = (state == refill_data) || (state == single_data);

	assign idu_valid = (state == deliver);
	assign out.pc = pc;
	assign out.inst = inst;

	assign lookup_valid = (state == fetch_lookup) && !lookup_sent && cacheable;
	assign lookup_addr = pc;

	assign fill_valid = (state == refill_data) && beat_accept;
	assign fill_data = r.data;

	assign hit_event = lookup_done && lookup_hit;
	assign miss_event = lookup_done && !lookup_hit;
	assign refill_start = miss_event;

	assign stalled = (state == refill_addr) || (state == refill_data) ||
		(state == single_addr) || (state == single_data);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_lookup;
			pc <= reset_pc;
			lookup_sent <= 1'b0;
		end else begin
			lookup_sent <= (state == fetch_lookup) && cacheable && !lookup_sent;
			case (state)
				fetch_idle: begin
					if (wb_valid) begin
						pc <= jump_addr;
						state <= fetch_lookup;
					end
				end
				fetch_lookup: begin
					if (!cacheable) begin
						state <= single_addr;
					end else if (lookup_sent) begin
						state <= lookup_hit ? deliver : refill_addr;
					end
				end
				refill_addr: begin
					if (ar_ready) begin
						state <= refill_data;
					end
				end
				refill_data: begin
					if (beat_accept && r.last) begin
						state <= deliver;
					end
				end
				single_addr: begin
					if (ar_ready) begin
						state <= single_data;
					end
				end
				single_data: begin
					if (beat_accept) begin
						state <= deliver;
					end
				end
				deliver: begin
					if (idu_ready) begin
						state <= fetch_idle;
					end
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	// Instruction comes from the hit, the matching refill beat or the single beat
	always_ff @(posedge clock) begin
		if (hit_event) begin
			inst <= lookup_word;
		end else if (fill_valid && beat_index == pc[line_offset_bits-1:2]) begin
			inst <= r.data;
		end else if ((state == single_data) && beat_accept) begin
			inst <= r.data;
		end
	end

	ar_stable: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

	wb_only_idle: assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> state == fetch_idle);

endmodule

/* icache_array.sv */
`timescale 1ns/1ps

module icache_array #(
	parameter int line_count = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        lookup_valid,
	input  logic [31:0] lookup_addr,
	input  logic        fill_valid,
	input  logic [31:0] fill_data,
	input  logic [1:0]  beat_index,
	output logic        lookup_hit,
	output logic [31:0] lookup_word
);
	import fetch_pkg::*;

	localparam int index_bits = $clog2(line_count);
	localparam int tag_bits = 32 - line_offset_bits - index_bits;
	localparam int word_bits = $clog2(words_per_line);

	logic [line_count-1:0] line_valid;
	logic [tag_bits-1:0]   tag_mem [line_count];
	logic [31:0]           data_mem [line_count][words_per_line];

	logic [index_bits-1:0] index;
	logic [tag_bits-1:0]   tag;
	logic [word_bits-1:0]  word;
	logic                  fill_first;
	logic                  fill_final;

	assign index = lookup_addr[line_offset_bits +: index_bits];
	assign tag = lookup_addr[31 -: tag_bits];
	assign word = lookup_addr[line_offset_bits-1 -: word_bits];

	assign fill_first = fill_valid && (beat_index == 2'd0);
	assign fill_final = fill_valid && (beat_index == 2'(words_per_line - 1));

	// Line is invalid while it is partly refilled
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_final) begin
			line_valid[index] <= 1'b1;
		end else if (fill_first) begin
			line_valid[index] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[index][beat_index] <= fill_data;
		end
		if (fill_final) begin
			tag_mem[index] <= tag;
		end
	end

	// Registered lookup
	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_hit <= 1'b0;
		end else begin
			lookup_hit <= lookup_valid && line_valid[index] && (tag_mem[index] == tag);
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			lookup_word <= data_mem[index][word];
		end
	end

	no_lookup_during_fill: assert property (@(posedge clock) disable iff (reset)
		!(lookup_valid && fill_valid));

endmodule

/* fetch_counters.sv */
`timescale 1ns/1ps

module fetch_counters (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   refill_start,
	input  logic                   fill_valid,
	input  logic                   hit_event,
	input  logic                   miss_event,
	input  logic                   stalled,
	output logic [1:0]             beat_index,
	output fetch_pkg::perf_counts_t perf
);
	import fetch_pkg::*;

	logic last_word;
	logic line_full;

	assign last_word = (beat_index == 2'(words_per_line - 1));

	// Word position inside the line being refilled
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_index <= 2'd0;
		end else if (refill_start) begin
			beat_index <= 2'd0;
		end else if (fill_valid) begin
			beat_index <= beat_index + 2'd1;
		end
	end

	// Set once the final word of a line has been written
	always_ff @(posedge clock) begin
		if (reset) begin
			line_full <= 1'b0;
		end else if (refill_start) begin
			line_full <= 1'b0;
		end else if (fill_valid && last_word) begin
			line_full <= 1'b1;
		end
	end

	// Counters wrap at 32 bits
	always_ff @(posedge clock) begin
		if (reset) begin
			perf <= '0;
		end else begin
			perf.hits <= perf.hits + 32'(hit_event);
			perf.misses <= perf.misses + 32'(miss_event);
			perf.stall_cycles <= perf.stall_cycles + 32'(stalled);
		end
	end

	beat_in_line: assert property (@(posedge clock) disable iff (reset)
		line_full |-> !fill_valid);

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [31:0] reset_pc    = 32'h3000_0000,
	parameter logic [31:0] cache_base  = 32'ha000_0000,
	parameter logic [31:0] cache_limit = 32'ha200_0000,
	parameter int          line_count  = 16
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      wb_valid,
	input  logic [31:0]               jump_addr,
	output logic                      ar_valid,
	output fetch_pkg::mem_read_req_t  ar,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  fetch_pkg::mem_read_resp_t r,
	output logic                      r_ready,
	output logic                      idu_valid,
	output fetch_pkg::fetch_out_t     out,
	input  logic                      idu_ready,
	output fetch_pkg::perf_counts_t   perf
);

	logic        lookup_valid;
	logic [31:0] lookup_addr;
	logic        lookup_hit;
	logic [31:0] lookup_word;
	logic        fill_valid;
	logic [31:0] fill_data;
	logic [1:0]  beat_index;
	logic        hit_event;
	logic        miss_event;
	logic        refill_start;
	logic        stalled;

	fetch_control #(
		.cache_base  (cache_base),
		.cache_limit (cache_limit),
		.reset_pc    (reset_pc)
	) control (
		.clock        (clock),
		.reset        (reset),
		.wb_valid     (wb_valid),
		.jump_addr    (jump_addr),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r            (r),
		.idu_ready    (idu_ready),
		.lookup_hit   (lookup_hit),
		.lookup_word  (lookup_word),
		.beat_index   (beat_index),
		.ar_valid     (ar_valid),
		.ar           (ar),
		.r_ready      (r_ready),
		.idu_valid    (idu_valid),
		.out          (out),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.fill_valid   (fill_valid),
		.fill_data    (fill_data),
		.hit_event    (hit_event),
		.miss_event   (miss_event),
		.refill_start (refill_start),
		.stalled      (stalled)
	);

	icache_array #(
		.line_count (line_count)
	) cache (
		.clock        (clock),
		.reset        (reset),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.fill_valid   (fill_valid),
		.fill_data    (fill_data),
		.beat_index   (beat_index),
		.lookup_hit   (lookup_hit),
		.lookup_word  (lookup_word)
	);

	fetch_counters counters (
		.clock        (clock),
		.reset        (reset),
		.refill_start (refill_start),
		.fill_valid   (fill_valid),
		.hit_event    (hit_event),
		.miss_event   (miss_event),
		.stalled      (stalled),
		.beat_index   (beat_index),
		.perf         (perf)
	);

endmodule

/* tb_memory_model.sv */
`timescale 1ns/1ps

module tb_memory_model (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      ar_valid,
	input  fetch_pkg::mem_read_req_t  ar,
	output logic                      ar_ready,
	output logic                      r_valid,
	output fetch_pkg::mem_read_resp_t r,
	input  logic                      r_ready
);
	import fetch_pkg::*;

	mem_read_req_t req;
	logic [31:0]   beat_addr;
	int            beat;

	// Memory content is a function of the word address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'h5a5a_5a5a;
	endfunction

	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		forever begin
			@(negedge clock);
			if (!reset && ar_valid) begin
				req = ar;
				repeat ($urandom_range(0, 3)) @(negedge clock);
				ar_ready = 1'b1;
				@(negedge clock);
				ar_ready = 1'b0;
				for (beat = 0; beat <= int'(req.len); beat++) begin
					repeat ($urandom_range(0, 3)) @(negedge clock);
					if (req.burst == burst_incr) begin
						beat_addr = req.addr + 32'(beat * 4);
					end else begin
						beat_addr = req.addr;
					end
					r.data = word_at(beat_addr);
					r.last = (beat == int'(req.len));
					r_valid = 1'b1;
					// Hold the beat until the fetch unit takes it
					while (!r_ready) @(negedge clock);
					@(negedge clock);
					r_valid = 1'b0;
				end
			end
		end
	end

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit;
	import fetch_pkg::*;

	localparam logic [31:0] reset_pc = 32'h3000_0000;
	localparam logic [31:0] cache_base = 32'ha000_0000;
	localparam logic [31:0] cache_limit = 32'ha200_0000;
	localparam int line_count = 16;
	localparam int index_bits = $clog2(line_count);
	localparam int fetch_count = 400;
	localparam int cycle_limit = fetch_count * 50;

	logic           clock;
	logic           reset;
	logic           wb_valid;
	logic [31:0]    jump_addr;
	logic           ar_valid;
	mem_read_req_t  ar;
	logic           ar_ready;
	logic           r_valid;
	mem_read_resp_t r;
	logic           r_ready;
	logic           idu_valid;
	fetch_out_t     out;
	logic           idu_ready;
	perf_counts_t   perf;

	// Reference model of the tag store
	logic        model_valid [line_count];
	logic [31:0] model_tag [line_count];
	logic [31:0] hits_exp;
	logic [31:0] misses_exp;
	logic [31:0] stalls_exp;

	mem_read_req_t req_log [$];
	logic          read_open;
	logic [31:0]   reuse_line;
	logic          reuse_valid;
	logic [31:0]   addr;
	int            latency;
	int            errors = 0;
	int            cycles = 0;
	int            fetches = 0;
	int unsigned   seed_result;

	fetch_unit #(
		.reset_pc    (reset_pc),
		.cache_base  (cache_base),
		.cache_limit (cache_limit),
		.line_count  (line_count)
	) UUT (
		.clock     (clock),
		.reset     (reset),
		.wb_valid  (wb_valid),
		.jump_addr (jump_addr),
		.ar_valid  (ar_valid),
		.ar        (ar),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r         (r),
		.r_ready   (r_ready),
		.idu_valid (idu_valid),
		.out       (out),
		.idu_ready (idu_ready),
		.perf      (perf)
	);

	tb_memory_model memory (
		.clock    (clock),
		.reset    (reset),
		.ar_valid (ar_valid),
		.ar       (ar),
		.ar_ready (ar_ready),
		.r_valid  (r_valid),
		.r        (r),
		.r_ready  (r_ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("ERROR: run stopped after %0d cycles, %0d fetches done, %0d errors",
				cycles, fetches, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Log every accepted read request, r_ready only while a read is open
	always @(posedge clock) begin
		if (reset) begin
			read_open = 1'b0;
		end else begin
			check_value("r_ready", 32'(r_ready), 32'(read_open));
			if (ar_valid && ar_ready) begin
				req_log.push_back(ar);
				read_open = 1'b1;
			end else if (r_valid && r_ready && r.last) begin
				read_open = 1'b0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_condition(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endtask

	function automatic logic [31:0] expected_word(input logic [31:0] a);
		return a ^ 32'h5a5a_5a5a;
	endfunction

	function automatic logic [index_bits-1:0] line_index(input logic [31:0] a);
		return a[line_offset_bits +: index_bits];
	endfunction

	function automatic logic [31:0] line_tag(input logic [31:0] a);
		return a >> (line_offset_bits + index_bits);
	endfunction

	// Small region, conflicting tags, or uncached, with some reuse of a missed line
	task automatic pick_address(output logic [31:0] a);
		logic [31:0] word;
		word = 32'($urandom_range(0, 63)) << 2;
		if (reuse_valid && $urandom_range(0, 1) == 1) begin
			a = {reuse_line[31:4], reuse_line[3:2] + 2'($urandom_range(1, 3)), 2'b00};
		end else begin
			case ($urandom_range(0, 2))
				0: a = cache_base + word;
				1: a = cache_base + (32'($urandom_range(1, 3)) << 16) + word;
				default: a = reset_pc + (32'($urandom_range(0, 1023)) << 2);
			endcase
		end
		reuse_valid = 1'b0;
	endtask

	// Latency counts edges after the one that loaded the pc
	task automatic wait_for_valid(output int lat);
		lat = 0;
		while (!idu_valid) begin
			idu_ready = 1'($urandom_range(0, 1));
			@(negedge clock);
			lat++;
		end
	endtask

	task automatic predict_and_check(input logic [31:0] a, input int lat);
		mem_read_req_t       req;
		logic                cached;
		logic                hit;
		logic [index_bits-1:0] idx;
		cached = (a >= cache_base) && (a < cache_limit);
		idx = line_index(a);
		hit = cached && model_valid[idx] && (model_tag[idx] == line_tag(a));
		if (!cached) begin
			stalls_exp = stalls_exp + 32'(lat - 1);
			check_condition(req_log.size() == 1, "uncached fetch did not issue one request");
			if (req_log.size() > 0) begin
				req = req_log[0];
				check_value("ar.addr", req.addr, a);
				check_value("ar.burst", 32'(req.burst), 32'(burst_fixed));
				check_value("ar.len", 32'(req.len), 32'd0);
			end
		end else if (hit) begin
			hits_exp = hits_exp + 32'd1;
			check_value("hit latency", 32'(lat), 32'd2);
			check_condition(req_log.size() == 0, "cache hit issued a read request");
		end else begin
			misses_exp = misses_exp + 32'd1;
			stalls_exp = stalls_exp + 32'(lat - 2);
			model_valid[idx] = 1'b1;
			model_tag[idx] = line_tag(a);
			reuse_line = a;
			reuse_valid = 1'b1;
			check_condition(req_log.size() == 1, "cache miss did not issue one request");
			if (req_log.size() > 0) begin
				req = req_log[0];
				check_value("ar.addr", req.addr, {a[31:4], 4'h0});
				check_value("ar.burst", 32'(req.burst), 32'(burst_incr));
				check_value("ar.len", 32'(req.len), 32'd3);
			end
		end
		req_log.delete();
		check_value("perf.hits", perf.hits, hits_exp);
		check_value("perf.misses", perf.misses, misses_exp);
		check_value("perf.stall_cycles", perf.stall_cycles, stalls_exp);
	endtask

	// Output must hold until the decoder takes it
	task automatic take_delivery(input logic [31:0] pc_exp);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			check_condition(idu_valid, "idu_valid dropped before idu_ready");
			check_value("out.pc", out.pc, pc_exp);
			check_value("out.inst", out.inst, expected_word(pc_exp));
			taken = 1'($urandom_range(0, 1));
			idu_ready = taken;
			@(negedge clock);
		end
		idu_ready = 1'b0;
		check_condition(!idu_valid, "idu_valid still high after the instruction was taken");
	endtask

	initial begin
		seed_result = $urandom(32'hfb1f_68fd);
		reset = 1'b1;
		wb_valid = 1'b0;
		jump_addr = 32'd0;
		idu_ready = 1'b0;
		model_valid = '{default: 1'b0};
		model_tag = '{default: 32'd0};
		hits_exp = 32'd0;
		misses_exp = 32'd0;
		stalls_exp = 32'd0;
		reuse_line = 32'd0;
		reuse_valid = 1'b0;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		// Fetch of reset_pc starts by itself
		wait_for_valid(latency);
		predict_and_check(reset_pc, latency);
		take_delivery(reset_pc);

		for (fetches = 0; fetches < fetch_count; fetches++) begin
			pick_address(addr);
			wb_valid = 1'b1;
			jump_addr = addr;
			@(negedge clock);
			wb_valid = 1'b0;
			wait_for_valid(latency);
			predict_and_check(addr, latency);
			take_delivery(addr);
		end

		check_value("perf.misses", perf.misses, misses_exp);
		$display("Done: %0d fetches, %0d hits, %0d misses, %0d errors",
			fetches, hits_exp, misses_exp, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
fetch_pkg.sv
fetch_control.sv
icache_array.sv
fetch_counters.sv
fetch_unit.sv
tb_memory_model.sv
tb_fetch_unit.sv

/* Makefile */
# Verilator build for the fetch stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module fetch_unit

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_fetch_unit
	@out="$$(./obj_dir/Vtb_fetch_unit)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
